//--- Bender.yml
package:
  name: pool_layer

sources:
  - hdl/cnn_pkg.sv
  - hdl/layer_ram.sv
  - hdl/window_fetch.sv
  - hdl/max_pool.sv
  - hdl/pool_layer.sv
  - target: test
    files:
      - tb/pool_checker.sv
      - tb/pool_layer_tb.sv

//--- hdl/cnn_pkg.sv
package cnn_pkg;

    //////////////////////////////////////////////////
    // feature map and pooling geometry
    //////////////////////////////////////////////////

    // side of the square input map
    localparam int unsigned map_size = 55;
    // 3x3 window, no overlap
    localparam int unsigned pool_win = 3;
    localparam int unsigned pool_stride = 3;

    // windows per row and column, 18 for a 55 wide map
    localparam int unsigned pool_out_size = (map_size - pool_win) / pool_stride + 1;
    localparam int unsigned pool_out_count = pool_out_size * pool_out_size;

    localparam int unsigned map_pixels = map_size * map_size;
    // two pixels per ram word, last word half used
    localparam int unsigned map_words = (map_pixels + 1) / 2;

    // pixels in one window
    localparam int unsigned win_len = pool_win * pool_win;

    //////////////////////////////////////////////////
    // data types
    //////////////////////////////////////////////////

    // one half precision value
    typedef logic [15:0] pixel_t;
    // even pixel in the low half, odd pixel in the high half
    typedef logic [2*$bits(pixel_t)-1:0] ram_word_t;
    typedef logic [$clog2(map_words)-1:0] word_addr_t;
    // row * map_size + col
    typedef logic [$clog2(map_pixels)-1:0] pixel_addr_t;
    // element 0 is top left, row major after that
    typedef logic [win_len*$bits(pixel_t)-1:0] win_vec_t;

    // window fetch sequencer
    typedef enum logic [1:0] {
        idle,
        read,
        flush
    } fetch_state_t;

    // unsigned key with the same order as fp16 values
    // negatives fully inverted, positives get the top bit set
    // so +0 sorts above -0
    function automatic logic [$bits(pixel_t)-1:0] fp16_key(pixel_t p);
        if (p[$bits(pixel_t)-1]) begin
            return ~p;
        end
        return p | {1'b1, {($bits(pixel_t) - 1){1'b0}}};
    endfunction

endpackage

//--- hdl/layer_ram.sv
`timescale 1ns/1ns

module layer_ram (
    input  logic               clk,
    input  logic               wr_en,
    input  cnn_pkg::word_addr_t  wr_addr,
    input  cnn_pkg::ram_word_t   wr_data,
    input  logic               rd_en,
    input  cnn_pkg::pixel_addr_t rd_addr,
    output cnn_pkg::pixel_t      rd_data
);
    import cnn_pkg::*;

    // even pixels (addr bit 0 clear)
    pixel_t bank_even [0:map_words-1];
    // odd pixels
    pixel_t bank_odd [0:map_words-1];

    // word index of the read pixel
    word_addr_t rd_word;

    assign rd_word = rd_addr[$bits(pixel_addr_t)-1:1];

    //////////////////////////////////////////////////
    // write port, one word = two pixels
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (wr_en) begin
            // low half to the even bank
            bank_even[wr_addr] <= wr_data[$bits(pixel_t)-1:0];
            bank_odd[wr_addr] <= wr_data[$bits(ram_word_t)-1:$bits(pixel_t)];
        end
    end

    //////////////////////////////////////////////////
    // read port, one pixel, registered
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rd_en) begin
            // bank picked by the lowest address bit
            if (rd_addr[0]) begin
                rd_data <= bank_odd[rd_word];
            end else begin
                rd_data <= bank_even[rd_word];
            end
        end
    end

endmodule

//--- hdl/max_pool.sv
`timescale 1ns/1ns

module max_pool (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            win_valid,
    input  cnn_pkg::win_vec_t win_vec,
    input  logic            win_last,
    output logic            pool_valid,
    output cnn_pkg::pixel_t   pool_out,
    output logic            pool_last
);
    import cnn_pkg::*;

    // window split into pixels
    pixel_t px [0:win_len-1];

    // tree stages 9 -> 5 -> 3 -> 2 -> 1
    pixel_t s1 [0:4];
    pixel_t s2 [0:2];
    pixel_t s3 [0:1];

    // flags beside the data, one bit per stage
    logic [3:0] vld_sr;
    logic [3:0] last_sr;

    // larger of two values in fp16 order
    function automatic pixel_t fp16_max(pixel_t a, pixel_t b);
        if (fp16_key(a) >= fp16_key(b)) begin
            return a;
        end
        return b;
    endfunction

    always_comb begin
        for (int i = 0; i < win_len; i++) begin
            px[i] = win_vec[i*$bits(pixel_t) +: $bits(pixel_t)];
        end
    end

    //////////////////////////////////////////////////
    // comparator tree
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        // stage 1, four pairs, element 8 passes
        for (int i = 0; i < 4; i++) begin
            s1[i] <= fp16_max(px[2*i], px[2*i+1]);
        end
        s1[4] <= px[win_len-1];

        // stage 2, two pairs
        s2[0] <= fp16_max(s1[0], s1[1]);
        s2[1] <= fp16_max(s1[2], s1[3]);
        s2[2] <= s1[4];

        // stage 3
        s3[0] <= fp16_max(s2[0], s2[1]);
        s3[1] <= s2[2];

        // stage 4, final max
        pool_out <= fp16_max(s3[0], s3[1]);
    end

    //////////////////////////////////////////////////
    // valid / last pipeline
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            vld_sr <= '0;
            last_sr <= '0;
        end else begin
            // several windows may be in flight
            vld_sr <= {vld_sr[2:0], win_valid};
            last_sr <= {last_sr[2:0], win_valid && win_last};
        end
    end

    // four cycles after win_valid
    assign pool_valid = vld_sr[3];
    assign pool_last = last_sr[3];

endmodule

//--- hdl/pool_layer.sv
`timescale 1ns/1ns

module pool_layer (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              start,
    input  logic              wr_en,
    input  cnn_pkg::word_addr_t wr_addr,
    input  cnn_pkg::ram_word_t  wr_data,
    output logic              busy,
    output logic              pool_valid,
    output cnn_pkg::pixel_t     pool_out,
    output logic              pool_last
);
    import cnn_pkg::*;

    // fetcher to ram
    logic        rd_en;
    pixel_addr_t rd_addr;
    pixel_t      rd_data;

    // fetcher to pool tree
    logic        win_valid;
    win_vec_t    win_vec;
    logic        win_last;

    //////////////////////////////////////////////////
    // feature map store
    //////////////////////////////////////////////////

    layer_ram u_layer_ram (
        .clk     (clk),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .rd_en   (rd_en),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    // window sequencer, 9 reads per window
    window_fetch u_window_fetch (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (start),
        .busy      (busy),
        .rd_en     (rd_en),
        .rd_addr   (rd_addr),
        .rd_data   (rd_data),
        .win_valid (win_valid),
        .win_vec   (win_vec),
        .win_last  (win_last)
    );

    // 4 stage max tree
    max_pool u_max_pool (
        .clk        (clk),
        .rst_n      (rst_n),
        .win_valid  (win_valid),
        .win_vec    (win_vec),
        .win_last   (win_last),
        .pool_valid (pool_valid),
        .pool_out   (pool_out),
        .pool_last  (pool_last)
    );

endmodule

//--- hdl/window_fetch.sv
`timescale 1ns/1ns

module window_fetch (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               start,
    output logic               busy,
    output logic               rd_en,
    output cnn_pkg::pixel_addr_t rd_addr,
    input  cnn_pkg::pixel_t      rd_data,
    output logic               win_valid,
    output cnn_pkg::win_vec_t    win_vec,
    output logic               win_last
);
    import cnn_pkg::*;

    fetch_state_t state;

    // top left corner of the current window
    logic [5:0] win_row;
    logic [5:0] win_col;
    // position inside the window
    logic [1:0] off_row;
    logic [1:0] off_col;

    // element number 0..8, row major
    logic [3:0] elem_idx;
    logic       off_col_end;
    logic       off_row_end;
    logic       last_elem;
    // window is the last in its row / the last row
    logic       col_end;
    logic       row_end;

    // absolute pixel row and column
    pixel_addr_t pix_row;
    pixel_addr_t pix_col;

    // read return tracking
    logic       rd_en_d;
    logic [3:0] elem_d;
    // elements 0..7, element 8 comes straight from the ram
    pixel_t     pack_q [0:win_len-2];

    //////////////////////////////////////////////////
    // status and address
    //////////////////////////////////////////////////

    assign busy = state != idle;
    // one read per cycle for the whole run
    assign rd_en = state == read;

    assign elem_idx = 4'(off_row) * 4'(pool_win) + 4'(off_col);
    assign off_col_end = off_col == 2'(pool_win - 1);
    assign off_row_end = off_row == 2'(pool_win - 1);
    assign last_elem = elem_idx == 4'(win_len - 1);
    assign col_end = win_col == 6'((pool_out_size - 1) * pool_stride);
    assign row_end = win_row == 6'((pool_out_size - 1) * pool_stride);

    assign pix_row = pixel_addr_t'(win_row) + pixel_addr_t'(off_row);
    assign pix_col = pixel_addr_t'(win_col) + pixel_addr_t'(off_col);
    // row * 55 + col, max 3024
    assign rd_addr = pix_row * pixel_addr_t'(map_size) + pix_col;

    //////////////////////////////////////////////////
    // fetch fsm
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= idle;
            win_row <= '0;
            win_col <= '0;
            off_row <= '0;
            off_col <= '0;
        end else begin
            case (state)
                idle: begin
                    // start only taken when not busy
                    if (start) begin
                        state <= read;
                    end
                end
                read: begin
                    if (off_col_end) begin
                        off_col <= '0;
                        if (off_row_end) begin
                            off_row <= '0;
                            // window done, step to the next one
                            if (col_end) begin
                                win_col <= '0;
                                if (row_end) begin
                                    win_row <= '0;
                                    state <= flush;
                                end else begin
                                    win_row <= win_row + 6'(pool_stride);
                                end
                            end else begin
                                win_col <= win_col + 6'(pool_stride);
                            end
                        end else begin
                            off_row <= off_row + 2'd1;
                        end
                    end else begin
                        off_col <= off_col + 2'd1;
                    end
                end
                // last read still in the ram
                flush: begin
                    state <= idle;
                end
                default: begin
                    state <= idle;
                end
            endcase
        end
    end

    //////////////////////////////////////////////////
    // read return and window strobe
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_en_d <= 1'b0;
            win_valid <= 1'b0;
            win_last <= 1'b0;
        end else begin
            rd_en_d <= rd_en;
            // ninth pixel lands next cycle
            win_valid <= rd_en && last_elem;
            win_last <= rd_en && last_elem && col_end && row_end;
        end
    end

    // element index follows the ram latency
    always_ff @(posedge clk) begin
        elem_d <= elem_idx;
        if (rd_en_d && elem_d != 4'(win_len - 1)) begin
            pack_q[elem_d[2:0]] <= rd_data;
        end
    end

    // pack the vector, top element bypasses the register
    always_comb begin
        for (int i = 0; i < win_len - 1; i++) begin
            win_vec[i*$bits(pixel_t) +: $bits(pixel_t)] = pack_q[i];
        end
        win_vec[(win_len-1)*$bits(pixel_t) +: $bits(pixel_t)] = rd_data;
    end

endmodule

//--- tb/pool_checker.sv
`timescale 1ns/1ns

module pool_checker (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            start,
    input  logic            busy,
    input  logic            pool_valid,
    input  cnn_pkg::pixel_t pool_out,
    input  logic            pool_last,
    output int              value_errors,
    output int              protocol_errors,
    output int              result_count,
    output int              run_count
);
    import cnn_pkg::*;

    // a start was accepted and its results are still due
    logic   armed;
    // raster index of the next expected result
    int     res_idx;
    pixel_t expected;

    // sign-magnitude to unsigned order, +0 above -0
    function automatic logic [15:0] order_key(pixel_t p);
        if (p[15]) begin
            return ~p;
        end
        return {1'b1, p[14:0]};
    endfunction

    // reference max of one window from the testbench copy of the map
    function automatic pixel_t window_max(int idx);
        int     base_row;
        int     base_col;
        pixel_t best;
        pixel_t cur;
        base_row = (idx / pool_out_size) * pool_stride;
        base_col = (idx % pool_out_size) * pool_stride;
        best = pool_layer_tb.map_model[base_row * map_size + base_col];
        for (int r = 0; r < pool_win; r++) begin
            for (int c = 0; c < pool_win; c++) begin
                cur = pool_layer_tb.map_model[(base_row + r) * map_size + base_col + c];
                if (order_key(cur) > order_key(best)) begin
                    best = cur;
                end
            end
        end
        return best;
    endfunction

    initial begin
        value_errors = 0;
        protocol_errors = 0;
        result_count = 0;
        run_count = 0;
        armed = 1'b0;
        res_idx = 0;
    end

    //////////////////////////////////////////////////
    // sampled mid-cycle, away from the clock edge
    //////////////////////////////////////////////////

    always @(negedge clk) begin
        if (!rst_n) begin
            // in-flight results are dropped by the reset
            armed = 1'b0;
            res_idx = 0;
        end else begin
            if (start && !busy && !armed) begin
                armed = 1'b1;
                res_idx = 0;
            end
            if (busy && !armed) begin
                protocol_errors++;
                $display("busy is high at %0t without an accepted start", $time);
            end
            if (pool_valid) begin
                if (!armed) begin
                    protocol_errors++;
                    $display("pool_valid came at %0t outside of a run", $time);
                end else if (res_idx >= pool_out_count) begin
                    protocol_errors++;
                    $display("more than %0d results in one run at %0t", pool_out_count, $time);
                end else begin
                    expected = window_max(res_idx);
                    result_count++;
                    if (pool_out !== expected) begin
                        value_errors++;
                        $display("FAILED @%0t: result %0d is %h, expected %h",
                                 $time, res_idx, pool_out, expected);
                    end
                    if (pool_last) begin
                        if (res_idx != pool_out_count - 1) begin
                            protocol_errors++;
                            $display("pool_last came early on result %0d at %0t",
                                     res_idx, $time);
                        end
                        armed = 1'b0;
                        res_idx = 0;
                        run_count++;
                    end else begin
                        if (res_idx == pool_out_count - 1) begin
                            protocol_errors++;
                            $display("pool_last is missing on the final result at %0t", $time);
                        end
                        res_idx++;
                    end
                end
            end else if (pool_last) begin
                protocol_errors++;
                $display("pool_last came without pool_valid at %0t", $time);
            end
        end
    end

endmodule

//--- tb/pool_layer_tb.sv
`timescale 1ns/1ns

module pool_layer_tb;
    import cnn_pkg::*;

    // two loads, three runs and idle gaps, with margin
    localparam int timeout_cycles = 15000;

    logic       clk;
    logic       rst_n;
    logic       start;
    logic       wr_en;
    word_addr_t wr_addr;
    ram_word_t  wr_data;
    logic       busy;
    logic       pool_valid;
    pixel_t     pool_out;
    logic       pool_last;

    // copy of the map as written, read by the checker
    pixel_t map_model [0:map_pixels-1];
    // one shared value per window for the equal-value class
    pixel_t win_fill [0:pool_out_count-1];

    int seed_val;
    int cycle_count;
    int tb_errors;
    int value_errors;
    int protocol_errors;
    int result_count;
    int run_count;

    pool_layer DUT (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .wr_en      (wr_en),
        .wr_addr    (wr_addr),
        .wr_data    (wr_data),
        .busy       (busy),
        .pool_valid (pool_valid),
        .pool_out   (pool_out),
        .pool_last  (pool_last)
    );

    pool_checker CHK (
        .clk             (clk),
        .rst_n           (rst_n),
        .start           (start),
        .busy            (busy),
        .pool_valid      (pool_valid),
        .pool_out        (pool_out),
        .pool_last       (pool_last),
        .value_errors    (value_errors),
        .protocol_errors (protocol_errors),
        .result_count    (result_count),
        .run_count       (run_count)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            $display("timeout, the run did not finish within %0d cycles", timeout_cycles);
            $display("TEST FAILED");
            $finish;
        end
    end

    //////////////////////////////////////////////////
    // stimulus helpers
    //////////////////////////////////////////////////

    task automatic idle_cycles(int n);
        repeat (n) @(posedge clk);
    endtask

    task automatic apply_reset();
        @(posedge clk);
        rst_n <= 1'b0;
        idle_cycles(2);
        rst_n <= 1'b1;
    endtask

    // full range, NaN and inf included
    task automatic fill_random_map();
        for (int i = 0; i < map_pixels; i++) begin
            map_model[i] = pixel_t'($urandom());
        end
    endtask

    // window class by index mod 4
    // negatives, signed zeros, equal values, negatives with -0
    task automatic fill_corner_map();
        int win_span;
        int cls;
        int idx;
        win_span = pool_out_size * pool_stride;
        for (int k = 0; k < pool_out_count; k++) begin
            win_fill[k] = pixel_t'($urandom());
        end
        for (int r = 0; r < map_size; r++) begin
            for (int c = 0; c < map_size; c++) begin
                idx = r * map_size + c;
                if (r >= win_span || c >= win_span) begin
                    // never inside a window
                    map_model[idx] = pixel_t'($urandom());
                end else begin
                    cls = ((r / pool_stride) * pool_out_size + c / pool_stride) % 4;
                    case (cls)
                        0: map_model[idx] = {1'b1, 15'($urandom())};
                        1: map_model[idx] = ($urandom() & 1) ? 16'h0000 : 16'h8000;
                        2: map_model[idx] = win_fill[(r / pool_stride) * pool_out_size
                                                     + c / pool_stride];
                        default: begin
                            if ($urandom() % 4 == 0) begin
                                map_model[idx] = 16'h8000;
                            end else begin
                                map_model[idx] = {1'b1, 15'($urandom())};
                            end
                        end
                    endcase
                end
            end
        end
    endtask

    // one word per cycle, even pixel in the low half
    task automatic load_map();
        pixel_t odd_px;
        for (int w = 0; w < map_words; w++) begin
            odd_px = (2 * w + 1 < map_pixels) ? map_model[2 * w + 1] : '0;
            @(posedge clk);
            wr_en <= 1'b1;
            wr_addr <= word_addr_t'(w);
            wr_data <= {odd_px, map_model[2 * w]};
        end
        @(posedge clk);
        wr_en <= 1'b0;
    endtask

    task automatic start_run();
        @(posedge clk);
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
    endtask

    task automatic wait_run_end();
        do begin
            @(posedge clk);
        end while (!pool_last);
    endtask

    //////////////////////////////////////////////////
    // test sequence
    //////////////////////////////////////////////////

    initial begin
        clk = 1'b0;
        rst_n = 1'b0;
        start = 1'b0;
        wr_en = 1'b0;
        wr_addr = '0;
        wr_data = '0;
        cycle_count = 0;
        tb_errors = 0;
        seed_val = $urandom(27228);

        idle_cycles(2);
        rst_n <= 1'b1;
        // quiet after reset, the checker flags any stray output
        idle_cycles(20);

        // random map, plus an extra start while busy
        fill_random_map();
        load_map();
        start_run();
        idle_cycles(100);
        if (!busy) begin
            tb_errors++;
            $display("DUT is not busy 100 cycles into the first run");
        end
        start_run();
        wait_run_end();
        idle_cycles(20);

        // ordering corner cases
        fill_corner_map();
        load_map();
        start_run();
        wait_run_end();
        idle_cycles(20);

        // two complete runs so far
        if (run_count != 2 || result_count != 2 * pool_out_count) begin
            tb_errors++;
            $display("wrong result count, %0d runs and %0d results", run_count, result_count);
        end

        // reset partway through a run
        start_run();
        idle_cycles(500);
        apply_reset();
        idle_cycles(200);

        if (run_count != 2) begin
            tb_errors++;
            $display("a run completed after the reset, %0d runs in total", run_count);
        end

        $display("errors: value %0d, protocol %0d, testbench %0d, results %0d",
                 value_errors, protocol_errors, tb_errors, result_count);
        if (value_errors + protocol_errors + tb_errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- verilog.f
hdl/cnn_pkg.sv
hdl/layer_ram.sv
hdl/window_fetch.sv
hdl/max_pool.sv
hdl/pool_layer.sv
tb/pool_checker.sv
tb/pool_layer_tb.sv
